// File: pk_pkg.sv
// shared constants and types for the front panel
// timing values assume CLK_EXT at 125 MHz and a 1 Mbaud host link
// every counter width is derived here from the rates below

package pk_pkg;

	localparam int CLK_HZ = 125_000_000;
	localparam int BAUD = 1_000_000;
	localparam int CLKS_PER_BIT = CLK_HZ / BAUD;
	localparam int MS_DIV = CLK_HZ / 1000;
	localparam int TIMER_CYCLE_MS = 10;
	localparam int DIGIT_CYCLES = 1024;

	// counter widths and terminal counts
	localparam int BIT_CNT_W = $clog2(CLKS_PER_BIT);
	localparam int MS_CNT_W = $clog2(MS_DIV);
	localparam int TIMER_CNT_W = $clog2(TIMER_CYCLE_MS);
	localparam int DIGIT_CNT_W = $clog2(DIGIT_CYCLES);
	localparam logic [BIT_CNT_W-1:0] BIT_LAST = BIT_CNT_W'(CLKS_PER_BIT - 1);
	localparam logic [BIT_CNT_W-1:0] HALF_BIT_LAST = BIT_CNT_W'(CLKS_PER_BIT / 2 - 1);
	localparam logic [MS_CNT_W-1:0] MS_LAST = MS_CNT_W'(MS_DIV - 1);
	localparam logic [TIMER_CNT_W-1:0] TIMER_LOAD = TIMER_CNT_W'(TIMER_CYCLE_MS - 1);
	localparam logic [DIGIT_CNT_W-1:0] DIGIT_LAST = DIGIT_CNT_W'(DIGIT_CYCLES - 1);

	// function keys: 12 of them, only START, MODE, CLOCK latch
	localparam int FN_COUNT = 12;
	localparam logic [FN_COUNT-1:0] FN_MOMENTARY = 12'hff8;

	// opcode in command byte bits 7..5
	typedef enum logic [2:0] {
		CMD_NONE = 3'd0,
		CMD_FN = 3'd1,
		CMD_KEYS_LO_A = 3'd2,
		CMD_KEYS_LO_B = 3'd3,
		CMD_KEYS_MID = 3'd4,
		CMD_KEYS_HI = 3'd5,
		CMD_LEDS = 3'd6,
		CMD_ROTARY = 3'd7
	} cmd_op_t;

	typedef enum logic [3:0] {
		FN_START, FN_MODE, FN_CLOCK, FN_STOPN,
		FN_STEP, FN_FETCH, FN_STORE, FN_CYCLE,
		FN_LOAD, FN_BIN, FN_OPRQ, FN_CLEAR
	} fn_key_t;

	// code 15 is not a position, it leaves the selector where it is
	typedef enum logic [3:0] {
		ROT_R0, ROT_R1, ROT_R2, ROT_R3, ROT_R4, ROT_R5, ROT_R6, ROT_R7,
		ROT_IC, ROT_AC, ROT_AR, ROT_IR, ROT_RS, ROT_RZ, ROT_KB
	} rot_pos_t;

	typedef struct packed {
		logic [15:0] keys;
		logic [FN_COUNT-1:0] fn_level;
		rot_pos_t rot;
	} panel_state_t;

	// all lamps active high
	typedef struct packed {
		logic [15:0] w;
		logic p;
		logic mc;
		logic run;
		logic wait_lamp;
		logic alarm;
		logic irq;
		logic q;
		logic mode;
		logic stop_n;
		logic zeg;
	} lamp_t;

	typedef struct packed {
		logic wre_;
		logic rsc;
		logic rsb;
		logic rsa;
		logic wic;
		logic wac;
		logic war;
		logic wir;
		logic wrs;
		logic wrz;
		logic wkb;
	} rot_lines_t;

endpackage

// File: uart_rx.sv
// 8N1 receiver, one byte per rx_valid pulse
// no parity, no framing report: a byte with a low stop bit is dropped
// start bits shorter than half a bit period count as noise

`timescale 1ns/1ps

module uart_rx (
	input logic CLK_EXT,
	input logic rst,
	input logic rxd,
	output logic [7:0] rx_byte,
	output logic rx_valid
);

	typedef enum logic [1:0] {ST_IDLE, ST_START, ST_DATA, ST_STOP} rx_state_t;

	rx_state_t st;
	logic [1:0] sync;
	logic rxd_s;
	logic [pk_pkg::BIT_CNT_W-1:0] cnt;
	logic [2:0] bit_idx;
	logic sample;

	assign rxd_s = sync[1];
	assign sample = (st == ST_DATA) && (cnt == pk_pkg::BIT_LAST);

	always_ff @(posedge CLK_EXT) begin
		if (rst) begin
			st <= ST_IDLE;
			sync <= 2'b11;
			cnt <= '0;
			bit_idx <= '0;
			rx_valid <= 1'b0;
		end else begin
			sync <= {sync[0], rxd};
			rx_valid <= 1'b0;
			case (st)
				ST_IDLE: begin
					cnt <= '0;
					bit_idx <= '0;
					if (!rxd_s)
						st <= ST_START;
				end
				ST_START: begin
					// line went back high before mid-bit
					if (rxd_s) begin
						st <= ST_IDLE;
					end else if (cnt == pk_pkg::HALF_BIT_LAST) begin
						cnt <= '0;
						st <= ST_DATA;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				ST_DATA: begin
					if (cnt == pk_pkg::BIT_LAST) begin
						cnt <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							st <= ST_STOP;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				ST_STOP: begin
					if (cnt == pk_pkg::BIT_LAST) begin
						rx_valid <= rxd_s;
						st <= ST_IDLE;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: st <= ST_IDLE;
			endcase
		end
	end

	// lsb first
	always_ff @(posedge CLK_EXT) begin
		if (sample)
			rx_byte <= {rxd_s, rx_byte[7:1]};
	end

	a_valid_single: assert property (@(posedge CLK_EXT) disable iff (rst)
		rx_valid |=> !rx_valid);

endmodule

// File: panel_regs.sv
// panel key and selector registers, written by host command bytes
// each byte is applied in the cycle rx_valid is high, nothing is queued
// LED readback bytes are accepted and ignored

`timescale 1ns/1ps

module panel_regs (
	input logic CLK_EXT,
	input logic rst,
	input logic [7:0] rx_byte,
	input logic rx_valid,
	output pk_pkg::panel_state_t state
);

	pk_pkg::cmd_op_t op;
	logic [3:0] fn_idx;
	logic fn_write;
	logic rot_write;
	logic [15:0] keys_next;
	logic [pk_pkg::FN_COUNT-1:0] fn_next;

	assign op = pk_pkg::cmd_op_t'(rx_byte[7:5]);
	assign fn_idx = rx_byte[4:1];

	// indices 12..15 name no key
	assign fn_write = rx_valid && (op == pk_pkg::CMD_FN) &&
		(int'(fn_idx) < pk_pkg::FN_COUNT);

	// code 15 on the rotary keeps the old position
	assign rot_write = rx_valid && (op == pk_pkg::CMD_ROTARY) &&
		(rx_byte[3:0] != 4'hf);

	// data key groups
	always_comb begin
		keys_next = state.keys;
		if (rx_valid) begin
			case (op)
				pk_pkg::CMD_KEYS_LO_A,
				pk_pkg::CMD_KEYS_LO_B: keys_next[5:0] = rx_byte[5:0];
				pk_pkg::CMD_KEYS_MID: keys_next[10:6] = rx_byte[4:0];
				pk_pkg::CMD_KEYS_HI: keys_next[15:11] = rx_byte[4:0];
				default: keys_next = state.keys;
			endcase
		end
	end

	// momentary keys fall back every cycle, so a press lasts one clock
	always_comb begin
		fn_next = state.fn_level & ~pk_pkg::FN_MOMENTARY;
		if (fn_write)
			fn_next[fn_idx] = rx_byte[0];
	end

	always_ff @(posedge CLK_EXT) begin
		if (rst) begin
			state.keys <= '0;
			state.fn_level <= '0;
			state.rot <= pk_pkg::ROT_R1;
		end else begin
			state.keys <= keys_next;
			state.fn_level <= fn_next;
			if (rot_write)
				state.rot <= pk_pkg::rot_pos_t'(rx_byte[3:0]);
		end
	end

	a_rot_valid: assert property (@(posedge CLK_EXT) disable iff (rst)
		state.rot != pk_pkg::rot_pos_t'(4'hf));

endmodule

// File: panel_signals.sv
// CPU-side control lines derived from the panel state
// hlt_n_ and p0_ are taken as synchronous to CLK_EXT
// start_n and stop_n_pulse come one clock after the key change

`timescale 1ns/1ps

module panel_signals (
	input logic CLK_EXT,
	input logic rst,
	input pk_pkg::panel_state_t state,
	input logic hlt_n_,
	input logic p0_,
	output logic work,
	output logic mode,
	output logic zeg,
	output logic stop_n,
	output logic start_n,
	output logic stop_n_pulse,
	output logic [15:0] kl,
	output logic dcl_,
	output logic step_,
	output logic fetch_,
	output logic store_,
	output logic cycle_,
	output logic load_,
	output logic bin_,
	output logic oprq_,
	output logic zegar_,
	output pk_pkg::rot_lines_t rot_lines
);

	logic [pk_pkg::FN_COUNT-1:0] fn;
	logic start_d;
	logic [pk_pkg::MS_CNT_W-1:0] ms_cnt;
	logic [pk_pkg::TIMER_CNT_W-1:0] timer_cnt;

	assign fn = state.fn_level;
	assign work = fn[pk_pkg::FN_START];
	assign mode = fn[pk_pkg::FN_MODE];
	assign zeg = fn[pk_pkg::FN_CLOCK];

	// start edge detect
	always_ff @(posedge CLK_EXT) begin
		if (rst) begin
			start_d <= 1'b0;
			start_n <= 1'b1;
			stop_n_pulse <= 1'b1;
		end else begin
			start_d <= work;
			start_n <= ~(work & ~start_d);
			stop_n_pulse <= ~(~work & start_d);
		end
	end

	// stop-on-address, halt clears it
	always_ff @(posedge CLK_EXT) begin
		if (rst || !hlt_n_)
			stop_n <= 1'b0;
		else if (fn[pk_pkg::FN_STOPN])
			stop_n <= ~stop_n;
	end

	// CPU bit 0 is the msb of the keys
	assign kl = {<<{state.keys}};

	assign dcl_ = ~fn[pk_pkg::FN_CLEAR];
	assign step_ = ~fn[pk_pkg::FN_STEP];
	assign oprq_ = ~fn[pk_pkg::FN_OPRQ];
	// manual memory cycles only while the CPU is ready
	assign fetch_ = ~fn[pk_pkg::FN_FETCH] | p0_;
	assign store_ = ~fn[pk_pkg::FN_STORE] | p0_;
	assign cycle_ = ~fn[pk_pkg::FN_CYCLE] | p0_;
	assign load_ = ~fn[pk_pkg::FN_LOAD] | p0_;
	assign bin_ = ~fn[pk_pkg::FN_BIN] | p0_;

	always_comb begin
		rot_lines = '0;
		case (state.rot)
			pk_pkg::ROT_IC: rot_lines.wic = 1'b1;
			pk_pkg::ROT_AC: rot_lines.wac = 1'b1;
			pk_pkg::ROT_AR: rot_lines.war = 1'b1;
			pk_pkg::ROT_IR: rot_lines.wir = 1'b1;
			pk_pkg::ROT_RS: rot_lines.wrs = 1'b1;
			pk_pkg::ROT_RZ: rot_lines.wrz = 1'b1;
			pk_pkg::ROT_KB: rot_lines.wkb = 1'b1;
			default: begin
				// general registers R0..R7
				rot_lines.wre_ = 1'b1;
				{rot_lines.rsc, rot_lines.rsb, rot_lines.rsa} = state.rot[2:0];
			end
		endcase
	end

	// real-time clock: ms prescaler and ms down-counter
	always_ff @(posedge CLK_EXT) begin
		if (rst) begin
			ms_cnt <= '0;
			timer_cnt <= pk_pkg::TIMER_LOAD;
		end else if (ms_cnt == pk_pkg::MS_LAST) begin
			ms_cnt <= '0;
			timer_cnt <= (timer_cnt == '0) ? pk_pkg::TIMER_LOAD : timer_cnt - 1'b1;
		end else begin
			ms_cnt <= ms_cnt + 1'b1;
		end
	end

	assign zegar_ = ~(zeg && (timer_cnt == '0));

	a_start_stop_excl: assert property (@(posedge CLK_EXT) disable iff (rst)
		!(!start_n && !stop_n_pulse));

endmodule

// File: panel_display.sv
// 8-digit multiplexed seven-segment driver for w and the status lamps
// segments and digit selects are active low, segment order dp g f e d c b a
// each digit is lit for DIGIT_CYCLES clocks, no blanking between digits

`timescale 1ns/1ps

module panel_display (
	input logic CLK_EXT,
	input logic rst,
	input pk_pkg::lamp_t lamps,
	output logic [7:0] seg,
	output logic [7:0] dig
);

	logic [pk_pkg::DIGIT_CNT_W-1:0] scan_cnt;
	logic [2:0] digit;
	logic [6:0] glyph;
	logic [7:0] dots;

	// active-high g..a patterns
	function automatic logic [6:0] hex_glyph(input logic [3:0] h);
		case (h)
			4'h0: hex_glyph = 7'h3f;
			4'h1: hex_glyph = 7'h06;
			4'h2: hex_glyph = 7'h5b;
			4'h3: hex_glyph = 7'h4f;
			4'h4: hex_glyph = 7'h66;
			4'h5: hex_glyph = 7'h6d;
			4'h6: hex_glyph = 7'h7d;
			4'h7: hex_glyph = 7'h07;
			4'h8: hex_glyph = 7'h7f;
			4'h9: hex_glyph = 7'h6f;
			4'ha: hex_glyph = 7'h77;
			4'hb: hex_glyph = 7'h7c;
			4'hc: hex_glyph = 7'h39;
			4'hd: hex_glyph = 7'h5e;
			4'he: hex_glyph = 7'h79;
			default: hex_glyph = 7'h71;
		endcase
	endfunction

	always_ff @(posedge CLK_EXT) begin
		if (rst) begin
			scan_cnt <= '0;
			digit <= '0;
		end else if (scan_cnt == pk_pkg::DIGIT_LAST) begin
			scan_cnt <= '0;
			digit <= digit + 1'b1;
		end else begin
			scan_cnt <= scan_cnt + 1'b1;
		end
	end

	// dot n shows flag n
	assign dots = {lamps.run, lamps.wait_lamp, lamps.alarm, lamps.irq,
		lamps.mode, lamps.stop_n, lamps.zeg, lamps.q};

	always_comb begin
		case (digit)
			3'd0: glyph = hex_glyph(lamps.w[3:0]);
			3'd1: glyph = hex_glyph(lamps.w[7:4]);
			3'd2: glyph = hex_glyph(lamps.w[11:8]);
			3'd3: glyph = hex_glyph(lamps.w[15:12]);
			// p on segment a, mc on segment g
			3'd7: glyph = {lamps.mc, 5'b0, lamps.p};
			default: glyph = 7'h00;
		endcase
	end

	assign seg = ~{dots[digit], glyph};
	assign dig = ~(8'b1 << digit);

endmodule

// File: pk_top.sv
// front panel top: serial receiver, panel registers, CPU lines, display
// CPU status inputs are taken as they come, lamps follow them directly
// no serial transmit, the LED command gets no reply

`timescale 1ns/1ps

module pk_top (
	input logic CLK_EXT,
	input logic rst,
	input logic rxd,
	input logic hlt_n_,
	input logic p0_,
	input logic [15:0] w,
	input logic p_,
	input logic mc_,
	input logic alarm_,
	input logic wait_,
	input logic irq,
	input logic q,
	input logic run,
	output logic work,
	output logic mode,
	output logic zeg,
	output logic stop_n,
	output logic start_n,
	output logic stop_n_pulse,
	output logic [15:0] kl,
	output logic dcl_,
	output logic step_,
	output logic fetch_,
	output logic store_,
	output logic cycle_,
	output logic load_,
	output logic bin_,
	output logic oprq_,
	output logic zegar_,
	output pk_pkg::rot_lines_t rot_lines,
	output logic [7:0] seg,
	output logic [7:0] dig
);

	logic [7:0] rx_byte;
	logic rx_valid;
	pk_pkg::panel_state_t state;
	pk_pkg::lamp_t lamps;

	uart_rx i_uart_rx (
		.CLK_EXT(CLK_EXT),
		.rst(rst),
		.rxd(rxd),
		.rx_byte(rx_byte),
		.rx_valid(rx_valid)
	);

	panel_regs i_panel_regs (
		.CLK_EXT(CLK_EXT),
		.rst(rst),
		.rx_byte(rx_byte),
		.rx_valid(rx_valid),
		.state(state)
	);

	panel_signals i_panel_signals (
		.CLK_EXT(CLK_EXT),
		.rst(rst),
		.state(state),
		.hlt_n_(hlt_n_),
		.p0_(p0_),
		.work(work),
		.mode(mode),
		.zeg(zeg),
		.stop_n(stop_n),
		.start_n(start_n),
		.stop_n_pulse(stop_n_pulse),
		.kl(kl),
		.dcl_(dcl_),
		.step_(step_),
		.fetch_(fetch_),
		.store_(store_),
		.cycle_(cycle_),
		.load_(load_),
		.bin_(bin_),
		.oprq_(oprq_),
		.zegar_(zegar_),
		.rot_lines(rot_lines)
	);

	// lamps lit when the CPU line is active
	always_comb begin
		lamps.w = w;
		lamps.p = ~p_;
		lamps.mc = ~mc_;
		lamps.run = run;
		lamps.wait_lamp = ~wait_;
		lamps.alarm = ~alarm_;
		lamps.irq = irq;
		lamps.q = q;
		lamps.mode = mode;
		lamps.stop_n = stop_n;
		lamps.zeg = zeg;
	end

	panel_display i_panel_display (
		.CLK_EXT(CLK_EXT),
		.rst(rst),
		.lamps(lamps),
		.seg(seg),
		.dig(dig)
	);

endmodule

// File: tb_pk.sv
// directed testbench for pk_top, host bytes sent as 8N1 at CLKS_PER_BIT per bit
// a full run takes roughly 50 ms of simulated time, most of it in the clock test
// CPU inputs are driven on the rising edge, outputs read once they are stable

`timescale 1ns/1ps

module tb_pk;

	localparam int CPB = pk_pkg::CLKS_PER_BIT;
	localparam longint CLK_NS = 8;
	localparam logic [31:0] LFSR_TAPS = 32'hD000_0001;
	localparam int DISPLAY_ROUNDS = 4;
	localparam int BYTE_BUDGET = 100;
	// start, 8 data, stop, then two idle bit times
	localparam longint BYTE_NS = 12 * CPB * CLK_NS;
	localparam longint CLOCK_TEST_NS = longint'(12 + 35 + 2) * pk_pkg::MS_DIV * CLK_NS;
	localparam longint DISPLAY_NS = DISPLAY_ROUNDS * 2 * 8 * pk_pkg::DIGIT_CYCLES * CLK_NS;
	localparam longint TIMEOUT_NS =
		(CLOCK_TEST_NS + BYTE_BUDGET * BYTE_NS + DISPLAY_NS) * 3 / 2;

	// common-anode codes, dp g f e d c b a, low is lit
	localparam logic [7:0] SEG_CODES [16] = '{
		8'hC0, 8'hF9, 8'hA4, 8'hB0, 8'h99, 8'h92, 8'h82, 8'hF8,
		8'h80, 8'h90, 8'h88, 8'h83, 8'hC6, 8'hA1, 8'h86, 8'h8E
	};

	logic CLK_EXT;
	logic rst;
	logic rxd;
	logic hlt_n_;
	logic p0_;
	logic [15:0] w;
	logic p_;
	logic mc_;
	logic alarm_;
	logic wait_;
	logic irq;
	logic q;
	logic run;
	logic work;
	logic mode;
	logic zeg;
	logic stop_n;
	logic start_n;
	logic stop_n_pulse;
	logic [15:0] kl;
	logic dcl_;
	logic step_;
	logic fetch_;
	logic store_;
	logic cycle_;
	logic load_;
	logic bin_;
	logic oprq_;
	logic zegar_;
	pk_pkg::rot_lines_t rot_lines;
	logic [7:0] seg;
	logic [7:0] dig;

	int errors = 0;
	logic [31:0] lfsr = 32'h9784_7134;
	int step_lows = 0;
	int fetch_lows = 0;
	int start_lows = 0;
	int stopp_lows = 0;
	int zeg_lows = 0;
	int zeg_periods = 0;
	int zeg_bad = 0;
	int zeg_run = 0;
	// panel flags as the tests have set them
	logic exp_mode;
	logic exp_stop_n;
	logic exp_zeg;

	pk_top i_pk_top (.*);

	initial begin
		CLK_EXT = 1'b0;
		forever #4 CLK_EXT = ~CLK_EXT;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("watchdog expired after %0d ns, the tests did not finish", TIMEOUT_NS);
		$display("STATUS: FAIL");
		$finish;
	end

	// low-cycle counters, read by the tests only at rising edges
	always @(negedge CLK_EXT) begin
		if (!rst) begin
			if (!step_) step_lows++;
			if (!fetch_) fetch_lows++;
			if (!start_n) start_lows++;
			if (!stop_n_pulse) stopp_lows++;
			if (!zegar_) begin
				zeg_lows++;
				zeg_run++;
			end else if (zeg_run != 0) begin
				zeg_periods++;
				if (zeg_run != pk_pkg::MS_DIV) zeg_bad++;
				zeg_run = 0;
			end
		end
	end

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic b;
		int i;
		r = '0;
		for (i = 0; i < n; i++) begin
			b = lfsr[0];
			lfsr = lfsr >> 1;
			if (b) lfsr = lfsr ^ LFSR_TAPS;
			r = {r[30:0], b};
		end
		return r;
	endfunction

	function automatic logic [15:0] reverse16(input logic [15:0] v);
		logic [15:0] r;
		int i;
		for (i = 0; i < 16; i++) r[i] = v[15 - i];
		return r;
	endfunction

	// opcode 001, key index, new value
	function automatic logic [7:0] fn_byte(input int idx, input logic val);
		return {3'b001, 4'(idx), val};
	endfunction

	// R0..R7 raise wre_ with the register number, the rest one line each
	function automatic logic [10:0] rot_expect(input int pos);
		if (pos < 8) return {1'b1, 3'(pos), 7'b0};
		return 11'b1 << (14 - pos);
	endfunction

	// st: p_, mc_, alarm_, wait_, irq, q, run from bit 0 up
	function automatic logic [7:0] expected_seg(input int n, input logic [15:0] wv,
		input logic [6:0] st);
		logic [7:0] s;
		logic [7:0] dot;
		dot = {st[6], ~st[3], ~st[2], st[4], exp_mode, exp_stop_n, exp_zeg, st[5]};
		s = (n < 4) ? SEG_CODES[wv[4*n +: 4]] : 8'hFF;
		if (n == 7) begin
			if (!st[0]) s[0] = 1'b0;
			if (!st[1]) s[6] = 1'b0;
		end
		if (dot[n]) s[7] = 1'b0;
		return s;
	endfunction

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			errors++;
			$display("MISMATCH %s: expected %0h, actual %0h", name, exp, act);
		end
	endtask

	// ends on a rising edge, long after the byte took effect
	task automatic send_byte(input logic [7:0] b);
		int i;
		@(posedge CLK_EXT);
		rxd <= 1'b0;
		repeat (CPB) @(posedge CLK_EXT);
		for (i = 0; i < 8; i++) begin
			rxd <= b[i];
			repeat (CPB) @(posedge CLK_EXT);
		end
		rxd <= 1'b1;
		repeat (3 * CPB) @(posedge CLK_EXT);
	endtask

	task automatic wait_digit(input int n, output logic found);
		logic [7:0] sel;
		int cnt;
		sel = ~(8'd1 << n);
		cnt = 0;
		@(negedge CLK_EXT);
		while (dig !== sel && cnt < 2 * 8 * pk_pkg::DIGIT_CYCLES) begin
			@(negedge CLK_EXT);
			cnt++;
		end
		found = (dig === sel);
		if (!found) begin
			errors++;
			$display("display never selected digit %0d within two scan rounds", n);
		end
	endtask

	task automatic test_reset;
		@(negedge CLK_EXT);
		check("test_reset dig", 32'(8'hFE), 32'(dig));
		check("test_reset start_n", 32'(1), 32'(start_n));
		check("test_reset stop_n_pulse", 32'(1), 32'(stop_n_pulse));
		check("test_reset strobes", 32'(7'h7f),
			32'({dcl_, step_, fetch_, store_, cycle_, load_, bin_}));
		check("test_reset oprq_ zegar_", 32'(2'b11), 32'({oprq_, zegar_}));
		check("test_reset stop_n", 32'(0), 32'(stop_n));
		check("test_reset work", 32'(0), 32'(work));
		check("test_reset mode zeg", 32'(2'b00), 32'({mode, zeg}));
		check("test_reset kl", 32'(0), 32'(kl));
	endtask

	task automatic test_keys;
		logic [15:0] v;
		int i;
		for (i = 0; i < 8; i++) begin
			v = (i == 0) ? 16'hFFFF : 16'(rand_bits(16));
			// opcode bit 0 doubles as key 5
			send_byte({2'b01, v[5:0]});
			send_byte({3'b100, v[10:6]});
			send_byte({3'b101, v[15:11]});
			check("test_keys kl", 32'(reverse16(v)), 32'(kl));
		end
	endtask

	task automatic test_rotary;
		int pos;
		check("test_rotary reset position", 32'(rot_expect(1)), 32'(rot_lines));
		for (pos = 0; pos < 15; pos++) begin
			send_byte({4'hE, 4'(pos)});
			check("test_rotary lines", 32'(rot_expect(pos)), 32'(rot_lines));
		end
		send_byte(8'hEF);
		check("test_rotary invalid code", 32'(rot_expect(14)), 32'(rot_lines));
	endtask

	task automatic test_momentary;
		int s;
		s = step_lows;
		send_byte(fn_byte(4, 1'b1));
		check("test_momentary step", 1, step_lows - s);
		s = fetch_lows;
		send_byte(fn_byte(5, 1'b1));
		check("test_momentary fetch ready", 1, fetch_lows - s);
		@(posedge CLK_EXT);
		p0_ <= 1'b1;
		s = fetch_lows;
		send_byte(fn_byte(5, 1'b1));
		check("test_momentary fetch busy", 0, fetch_lows - s);
		p0_ <= 1'b0;
		send_byte(fn_byte(3, 1'b1));
		check("test_momentary stop_n first", 32'(1), 32'(stop_n));
		send_byte(fn_byte(3, 1'b1));
		check("test_momentary stop_n second", 32'(0), 32'(stop_n));
		send_byte(fn_byte(3, 1'b1));
		hlt_n_ <= 1'b0;
		@(posedge CLK_EXT);
		hlt_n_ <= 1'b1;
		@(negedge CLK_EXT);
		check("test_momentary halt clear", 32'(0), 32'(stop_n));
		exp_stop_n = 1'b0;
	endtask

	task automatic test_start;
		int s_start;
		int s_stop;
		s_start = start_lows;
		s_stop = stopp_lows;
		send_byte(fn_byte(0, 1'b1));
		check("test_start work on", 32'(1), 32'(work));
		check("test_start start_n pulses", 1, start_lows - s_start);
		check("test_start no stop pulse", 0, stopp_lows - s_stop);
		send_byte(fn_byte(0, 1'b0));
		check("test_start work off", 32'(0), 32'(work));
		check("test_start start_n total", 1, start_lows - s_start);
		check("test_start stop_n_pulse pulses", 1, stopp_lows - s_stop);
	endtask

	task automatic test_clock;
		int s_low;
		int s_per;
		int s_bad;
		int cnt;
		s_low = zeg_lows;
		repeat (12 * pk_pkg::MS_DIV) @(posedge CLK_EXT);
		check("test_clock off low cycles", 0, zeg_lows - s_low);
		send_byte(fn_byte(2, 1'b1));
		exp_zeg = 1'b1;
		check("test_clock zeg on", 32'(1), 32'(zeg));
		// start the window outside a low period
		cnt = 0;
		@(negedge CLK_EXT);
		while (!zegar_ && cnt < 2 * pk_pkg::MS_DIV) begin
			@(negedge CLK_EXT);
			cnt++;
		end
		@(posedge CLK_EXT);
		s_per = zeg_periods;
		s_bad = zeg_bad;
		repeat (35 * pk_pkg::MS_DIV) @(posedge CLK_EXT);
		if (zeg_periods - s_per < 3 || zeg_periods - s_per > 4) begin
			errors++;
			$display("test_clock saw %0d low periods of zegar_ in 35 ms, wanted 3 or 4",
				zeg_periods - s_per);
		end
		check("test_clock bad period lengths", 0, zeg_bad - s_bad);
		send_byte(fn_byte(2, 1'b0));
		exp_zeg = 1'b0;
		check("test_clock zeg off", 32'(0), 32'(zeg));
	endtask

	task automatic test_display;
		logic [15:0] wv;
		logic [6:0] st;
		logic found;
		int r;
		int n;
		send_byte(fn_byte(1, 1'b1));
		check("test_display mode on", 32'(1), 32'(mode));
		exp_mode = 1'(rand_bits(1));
		send_byte(fn_byte(1, exp_mode));
		check("test_display mode", 32'(exp_mode), 32'(mode));
		send_byte(fn_byte(3, 1'b1));
		exp_stop_n = ~exp_stop_n;
		check("test_display stop_n", 32'(exp_stop_n), 32'(stop_n));
		for (r = 0; r < DISPLAY_ROUNDS; r++) begin
			wv = 16'(rand_bits(16));
			st = 7'(rand_bits(7));
			@(posedge CLK_EXT);
			w <= wv;
			{run, q, irq, wait_, alarm_, mc_, p_} <= st;
			for (n = 0; n < 8; n++) begin
				wait_digit(n, found);
				if (found)
					check("test_display seg", 32'(expected_seg(n, wv, st)), 32'(seg));
			end
		end
	endtask

	initial begin
		rst <= 1'b1;
		rxd <= 1'b1;
		hlt_n_ <= 1'b1;
		p0_ <= 1'b0;
		w <= '0;
		p_ <= 1'b1;
		mc_ <= 1'b1;
		alarm_ <= 1'b1;
		wait_ <= 1'b1;
		irq <= 1'b0;
		q <= 1'b0;
		run <= 1'b0;
		exp_mode = 1'b0;
		exp_stop_n = 1'b0;
		exp_zeg = 1'b0;
		repeat (4) @(posedge CLK_EXT);
		rst <= 1'b0;
		test_reset;
		test_keys;
		test_rotary;
		test_momentary;
		test_start;
		test_clock;
		test_display;
		@(posedge CLK_EXT);
		$display("tests finished with %0d errors", errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// File: project.f
pk_pkg.sv
uart_rx.sv
panel_regs.sv
panel_signals.sv
panel_display.sv
pk_top.sv
tb_pk.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS = --binary --timing --assert -Wno-fatal -j 0
TOP = tb_pk
FILELIST = project.f
OBJ_DIR = obj_dir
BIN = $(OBJ_DIR)/V$(TOP)
PASS_MSG = STATUS: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
